/* build.f */
hdl/cpu_pkg.sv
hdl/mmio_pkg.sv
hdl/ex_wb.sv
hdl/perf_counters.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/wb_select.sv
hdl/io_wb_top.sv
test/tb_io_wb.sv

/* test/tb_io_wb.sv */
`timescale 1ns/1ps

module tb_io_wb import cpu_pkg::*, mmio_pkg::*; ();
    localparam int CLKS       = 4;
    localparam int FRAME      = 10 * CLKS;
    localparam int WATCHDOG   = 20 * FRAME + 2000;  // In clock cycles
    localparam int POLL_LIMIT = 4 * FRAME;

    logic       clk;
    logic       reset_i;
    ex_wb_s     ex_i;
    uart_ctrl_e mmio_ctrl_i;
    word_t      store_data_i;
    logic       inst_exec_i;
    word_t      mem_rdata_i;
    logic       wb_en_o;
    reg_addr_t  wb_addr_o;
    word_t      wb_data_o;
    logic       serial_tx_o;
    logic       exp_check;
    logic       exp_en;
    reg_addr_t  exp_addr;
    word_t      exp_data;
    logic       exp_rx_clear;
    word_t      mem_next;
    word_t      last_data;
    integer     seed;
    integer     errors;
    int         ops_since_clr;
    int         inst_seen;

    io_wb_top #(.CLKS_PER_BIT(CLKS)) i_dut (
        .clk          (clk),
        .reset_i      (reset_i),
        .ex_i         (ex_i),
        .mmio_ctrl_i  (mmio_ctrl_i),
        .store_data_i (store_data_i),
        .inst_exec_i  (inst_exec_i),
        .mem_rdata_i  (mem_rdata_i),
        .serial_rx_i  (serial_tx_o),  // Serial loopback
        .wb_en_o      (wb_en_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o),
        .serial_tx_o  (serial_tx_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Outputs settle after the rising edge, so all checks sample on the falling edge
    reset_state: assert property (@(negedge clk) reset_i |-> (!wb_en_o && serial_tx_o))
        else begin
            errors = errors + 1;
            $display("mismatch at %0t: wb_en_o/serial_tx_o expected 0/1, got %b/%b", $time,
                $sampled(wb_en_o), $sampled(serial_tx_o));
        end

    en_matches: assert property (@(negedge clk) disable iff (reset_i)
        exp_check |-> (wb_en_o == exp_en))
        else begin
            errors = errors + 1;
            $display("mismatch at %0t: wb_en_o expected %0h, got %0h", $time,
                $sampled(exp_en), $sampled(wb_en_o));
        end

    addr_matches: assert property (@(negedge clk) disable iff (reset_i)
        exp_check |-> (wb_addr_o == exp_addr))
        else begin
            errors = errors + 1;
            $display("mismatch at %0t: wb_addr_o expected %0h, got %0h", $time,
                $sampled(exp_addr), $sampled(wb_addr_o));
        end

    data_matches: assert property (@(negedge clk) disable iff (reset_i)
        exp_check |-> (wb_data_o == exp_data))
        else begin
            errors = errors + 1;
            $display("mismatch at %0t: wb_data_o expected %h, got %h", $time,
                $sampled(exp_data), $sampled(wb_data_o));
        end

    rx_valid_cleared: assert property (@(negedge clk) disable iff (reset_i)
        exp_rx_clear |-> !wb_data_o[1])
        else begin
            errors = errors + 1;
            $display("mismatch at %0t: wb_data_o[1] expected 0, got %b", $time,
                $sampled(wb_data_o[1]));
        end

    function automatic ex_wb_s make_ex(input word_t alu, input word_t pc4, input reg_addr_t rd,
                                       input wb_sel_e sel, input load_e kind, input logic en);
        ex_wb_s e;
        e            = '0;
        e.alu_result = alu;
        e.pc_plus4   = pc4;
        e.wb_addr    = rd;
        e.wb_sel     = sel;
        e.load       = kind;
        e.wb_en      = en;
        return e;
    endfunction

    // The addressed lane is shifted down to bit 0 and then extended
    function automatic word_t expect_load(input load_e kind, input word_t mem,
                                          input byte_off_t off);
        word_t lane;
        lane = mem >> (8 * off);
        case (kind)
            LD_LB:   return {{24{lane[7]}}, lane[7:0]};
            LD_LH:   return {{16{lane[15]}}, lane[15:0]};
            LD_LBU:  return {24'b0, lane[7:0]};
            LD_LHU:  return {16'b0, lane[15:0]};
            default: return mem;
        endcase
    endfunction

    // One instruction per call; last_data is what the previous one wrote back
    task automatic drive_op(input ex_wb_s ex, input uart_ctrl_e ctrl, input word_t store,
                            input logic check, input word_t data, input logic rx_clear);
        @(negedge clk);
        last_data    = wb_data_o;
        ex_i         = ex;
        mmio_ctrl_i  = ctrl;
        store_data_i = store;
        mem_rdata_i  = mem_next;
        inst_exec_i  = 1'($random(seed) & 1);
        exp_check    = check;
        exp_en       = ex.wb_en;
        exp_addr     = ex.wb_addr;
        exp_data     = data;
        exp_rx_clear = rx_clear;
        ops_since_clr++;
        if (inst_exec_i) inst_seen++;
    endtask

    task automatic bubble();
        drive_op(make_ex('0, '0, '0, WB_ALU, LD_NONE, 1'b0), UART_NONE, '0, 1'b1, '0, 1'b0);
    endtask

    task automatic mmio_read(input word_t addr, input reg_addr_t rd, input logic check,
                             input word_t data, input logic rx_clear);
        drive_op(make_ex(addr, '0, rd, WB_MMIO, LD_NONE, 1'b1), UART_READ, '0, check, data,
            rx_clear);
    endtask

    task automatic mmio_write(input word_t addr, input word_t store);
        drive_op(make_ex(addr, '0, '0, WB_ALU, LD_NONE, 1'b0), UART_WRITE, store, 1'b1, addr,
            1'b0);
    endtask

    task automatic poll_status(input int bit_idx);
        int tries;
        tries = 0;
        do begin
            mmio_read(STATUS_ADDR, 5'd1, 1'b0, '0, 1'b0);
            bubble();
            tries++;
        end while (!last_data[bit_idx] && tries < POLL_LIMIT);
        if (!last_data[bit_idx]) begin
            errors = errors + 1;
            $display("status bit %0d was never set while polling, at %0t", bit_idx, $time);
        end
    endtask

    initial begin
        word_t     alu;
        word_t     pc4;
        word_t     store;
        reg_addr_t rd;
        wb_sel_e   sel;
        load_e     kinds [5];
        int        gap;
        seed          = 32'h20e1;
        errors        = 0;
        reset_i       = 1'b1;
        ex_i          = '0;
        mmio_ctrl_i   = UART_NONE;
        store_data_i  = '0;
        inst_exec_i   = 1'b0;
        mem_rdata_i   = '0;
        mem_next      = '0;
        exp_check     = 1'b0;
        exp_en        = 1'b0;
        exp_addr      = '0;
        exp_data      = '0;
        exp_rx_clear  = 1'b0;
        ops_since_clr = 0;
        inst_seen     = 0;
        kinds         = '{LD_LB, LD_LH, LD_LW, LD_LBU, LD_LHU};
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        repeat (20) begin
            alu = $random(seed);
            pc4 = $random(seed);
            rd  = $random(seed);
            sel = ($random(seed) & 1) ? WB_PC4 : WB_ALU;
            drive_op(make_ex(alu, pc4, rd, sel, LD_NONE, rd[0]), UART_NONE, '0, 1'b1,
                (sel == WB_PC4) ? pc4 : alu, 1'b0);
        end

        repeat (4) begin
            mem_next = $random(seed);
            foreach (kinds[k]) begin
                for (int off = 0; off < 4; off++) begin
                    if (kinds[k] != LD_LW || off == 0) begin
                        alu      = $random(seed);
                        alu[1:0] = off[1:0];
                        rd       = $random(seed);
                        drive_op(make_ex(alu, '0, rd, WB_LOAD, kinds[k], 1'b1), UART_NONE, '0,
                            1'b1, expect_load(kinds[k], mem_next, off[1:0]), 1'b0);
                    end
                end
            end
        end

        repeat (6) begin
            store = $random(seed);
            poll_status(0);
            mmio_write(TX_DATA_ADDR, store);
            poll_status(1);
            mmio_read(RX_DATA_ADDR, 5'd2, 1'b1, {24'b0, store[7:0]}, 1'b0);
            mmio_read(STATUS_ADDR, 5'd3, 1'b0, '0, 1'b1);
        end

        repeat (3) begin
            mmio_write(COUNT_CLR_ADDR, $random(seed));
            ops_since_clr = 0;
            inst_seen     = 0;
            gap           = 2 + ($random(seed) & 15);
            repeat (gap) bubble();
            mmio_read(CYCLE_ADDR, 5'd4, 1'b1, ops_since_clr, 1'b0);
            mmio_read(INSTR_ADDR, 5'd5, 1'b1, inst_seen, 1'b0);
        end
        repeat (3) bubble();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("watchdog expired before the tests finished, at %0t", $time);
        $display("errors: %0d", errors);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* hdl/io_wb_top.sv */
`timescale 1ns/1ps

module io_wb_top import cpu_pkg::*, mmio_pkg::*; #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic       clk,
    input  logic       reset_i,
    input  ex_wb_s     ex_i,
    input  uart_ctrl_e mmio_ctrl_i,
    input  word_t      store_data_i,
    input  logic       inst_exec_i,
    input  word_t      mem_rdata_i,
    input  logic       serial_rx_i,
    output logic       wb_en_o,
    output reg_addr_t  wb_addr_o,
    output word_t      wb_data_o,
    output logic       serial_tx_o
);
    ex_wb_s     wb;
    word_t      mmio_rdata;
    word_t      cycle_count;
    word_t      inst_count;
    logic       count_clr;
    logic       tx_valid;
    logic       tx_ready;
    uart_byte_t tx_byte;
    logic       rx_valid;
    logic       rx_read;
    uart_byte_t rx_byte;

    ex_wb i_ex_wb (
        .clk           (clk),
        .reset_i       (reset_i),
        .ex_i          (ex_i),
        .mmio_ctrl_i   (mmio_ctrl_i),
        .store_data_i  (store_data_i),
        .rx_valid_i    (rx_valid),
        .rx_byte_i     (rx_byte),
        .tx_ready_i    (tx_ready),
        .cycle_count_i (cycle_count),
        .inst_count_i  (inst_count),
        .wb_o          (wb),
        .mmio_rdata_o  (mmio_rdata),
        .tx_valid_o    (tx_valid),
        .tx_byte_o     (tx_byte),
        .rx_read_o     (rx_read),
        .count_clr_o   (count_clr)
    );

    perf_counters i_perf_counters (
        .clk           (clk),
        .reset_i       (reset_i),
        .clear_i       (count_clr),
        .inst_exec_i   (inst_exec_i),
        .cycle_count_o (cycle_count),
        .inst_count_o  (inst_count)
    );

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_rx (
        .clk      (clk),
        .reset_i  (reset_i),
        .serial_i (serial_rx_i),
        .read_i   (rx_read),
        .valid_o  (rx_valid),
        .byte_o   (rx_byte)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_tx (
        .clk      (clk),
        .reset_i  (reset_i),
        .valid_i  (tx_valid),
        .byte_i   (tx_byte),
        .ready_o  (tx_ready),
        .serial_o (serial_tx_o)
    );

    wb_select i_wb_select (
        .wb_i         (wb),
        .mem_rdata_i  (mem_rdata_i),
        .mmio_rdata_i (mmio_rdata),
        .wb_en_o      (wb_en_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o)
    );

endmodule

/* hdl/wb_select.sv */
`timescale 1ns/1ps

module wb_select import cpu_pkg::*; (
    input  ex_wb_s    wb_i,
    input  word_t     mem_rdata_i,
    input  word_t     mmio_rdata_i,
    output logic      wb_en_o,
    output reg_addr_t wb_addr_o,
    output word_t     wb_data_o
);
    word_t     shifted;
    word_t     load_data;
    logic [4:0] shamt;

    // Move the addressed byte or halfword down to bit 0
    assign shamt   = {wb_i.byte_off, 3'b000};
    assign shifted = mem_rdata_i >> shamt;

    always_comb begin
        case (wb_i.load)
            LD_LB:   load_data = {{24{shifted[7]}}, shifted[7:0]};
            LD_LH:   load_data = {{16{shifted[15]}}, shifted[15:0]};
            LD_LBU:  load_data = {24'b0, shifted[7:0]};
            LD_LHU:  load_data = {16'b0, shifted[15:0]};
            default: load_data = mem_rdata_i;  // Word loads are aligned
        endcase
    end

    always_comb begin
        case (wb_i.wb_sel)
            WB_ALU:  wb_data_o = wb_i.alu_result;
            WB_PC4:  wb_data_o = wb_i.pc_plus4;   // Link value for jal and jalr
            WB_LOAD: wb_data_o = load_data;
            default: wb_data_o = mmio_rdata_i;
        endcase
    end

    assign wb_en_o   = wb_i.wb_en;
    assign wb_addr_o = wb_i.wb_addr;

endmodule

/* hdl/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx import mmio_pkg::*; #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       valid_i,
    input  uart_byte_t byte_i,
    output logic       ready_o,
    output logic       serial_o
);
    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    tx_state_e        state_q;
    logic [CNT_W-1:0] cnt_q;
    logic [2:0]       bit_idx_q;
    uart_byte_t       shift_q;
    logic             accept;
    logic             bit_end;

    assign ready_o = (state_q == TX_IDLE);
    assign accept  = valid_i && ready_o;
    assign bit_end = (cnt_q == LAST);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q   <= TX_IDLE;
            cnt_q     <= '0;
            bit_idx_q <= '0;
            serial_o  <= 1'b1;
        end else begin
            case (state_q)
                TX_IDLE: begin
                    if (accept) begin
                        state_q  <= TX_START;
                        serial_o <= 1'b0;  // Start bit on the clock after the handshake
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        state_q   <= TX_DATA;
                        bit_idx_q <= '0;
                        serial_o  <= shift_q[0];
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        bit_idx_q <= bit_idx_q + 1'b1;
                        if (bit_idx_q == 3'd7) begin
                            state_q  <= TX_STOP;
                            serial_o <= 1'b1;
                        end else begin
                            serial_o <= shift_q[1];
                        end
                    end
                end
                default: begin
                    if (bit_end) state_q <= TX_IDLE;
                end
            endcase
            if (state_q == TX_IDLE || bit_end) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // Bit 0 is already on the line when the data phase starts
    always_ff @(posedge clk) begin
        if (accept) begin
            shift_q <= byte_i;
        end else if (state_q == TX_DATA && bit_end) begin
            shift_q <= shift_q >> 1;
        end
    end

    idle_line_high: assert property (@(posedge clk) disable iff (reset_i)
        (state_q == TX_IDLE) |-> serial_o)
        else $error("serial line low while the transmitter is idle");

endmodule

/* hdl/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx import mmio_pkg::*; #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       serial_i,
    input  logic       read_i,
    output logic       valid_o,
    output uart_byte_t byte_o
);
    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF = CNT_W'((CLKS_PER_BIT - 1) / 2);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e        state_q;
    logic [CNT_W-1:0] cnt_q;
    logic [2:0]       bit_idx_q;
    uart_byte_t       shift_q;
    logic             rx_meta_q;
    logic             rx_sync_q;
    logic             sample_bit;
    logic             frame_done;

    // Two flops bring the line into the clock domain; idle level is high
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
        end else begin
            rx_meta_q <= serial_i;
            rx_sync_q <= rx_meta_q;
        end
    end

    assign sample_bit = (state_q == RX_DATA) && (cnt_q == LAST);
    assign frame_done = (state_q == RX_STOP) && (cnt_q == LAST) && rx_sync_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q   <= RX_IDLE;
            cnt_q     <= '0;
            bit_idx_q <= '0;
            valid_o   <= 1'b0;
        end else begin
            if (read_i) begin
                valid_o <= 1'b0;
            end
            case (state_q)
                RX_IDLE: begin
                    cnt_q <= '0;
                    if (!rx_sync_q) state_q <= RX_START;
                end
                RX_START: begin
                    if (cnt_q == HALF) begin
                        // Line went high again before mid-bit, so this was a glitch
                        state_q   <= rx_sync_q ? RX_IDLE : RX_DATA;
                        cnt_q     <= '0;
                        bit_idx_q <= '0;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (cnt_q == LAST) begin
                        cnt_q     <= '0;
                        bit_idx_q <= bit_idx_q + 1'b1;
                        if (bit_idx_q == 3'd7) state_q <= RX_STOP;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: begin
                    if (cnt_q == LAST) begin
                        state_q <= RX_IDLE;
                        cnt_q   <= '0;
                        if (frame_done) valid_o <= 1'b1;  // Wins over a read in the same cycle
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
            endcase
        end
    end

    // Bits arrive LSB first
    always_ff @(posedge clk) begin
        if (sample_bit) shift_q <= {rx_sync_q, shift_q[7:1]};
        if (frame_done) byte_o <= shift_q;
    end

endmodule

/* hdl/perf_counters.sv */
`timescale 1ns/1ps

module perf_counters import cpu_pkg::*; (
    input  logic  clk,
    input  logic  reset_i,
    input  logic  clear_i,
    input  logic  inst_exec_i,
    output word_t cycle_count_o,
    output word_t inst_count_o
);
    logic zero_counts;

    // A clear store in execute makes both counts read zero on the next cycle
    assign zero_counts = reset_i || clear_i;

    always_ff @(posedge clk) begin
        if (zero_counts) begin
            cycle_count_o <= '0;
        end else begin
            cycle_count_o <= cycle_count_o + 32'd1;  // Free running, wraps at 2^32
        end
    end

    always_ff @(posedge clk) begin
        if (zero_counts) begin
            inst_count_o <= '0;
        end else if (inst_exec_i) begin
            inst_count_o <= inst_count_o + 32'd1;
        end
    end

endmodule

/* hdl/ex_wb.sv */
`timescale 1ns/1ps

module ex_wb import cpu_pkg::*, mmio_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  ex_wb_s     ex_i,
    input  uart_ctrl_e mmio_ctrl_i,
    input  word_t      store_data_i,
    input  logic       rx_valid_i,
    input  uart_byte_t rx_byte_i,
    input  logic       tx_ready_i,
    input  word_t      cycle_count_i,
    input  word_t      inst_count_i,
    output ex_wb_s     wb_o,
    output word_t      mmio_rdata_o,
    output logic       tx_valid_o,
    output uart_byte_t tx_byte_o,
    output logic       rx_read_o,
    output logic       count_clr_o
);
    word_t      mmio_addr;
    word_t      mmio_rdata;
    logic       is_read;
    logic       is_write;
    uart_byte_t rx_byte_q;
    ex_wb_s     wb_d;
    ex_wb_s     wb_q;
    logic       wb_en_q;

    assign mmio_addr = ex_i.alu_result;  // The ALU computes the load/store address
    assign is_read   = (mmio_ctrl_i == UART_READ);
    assign is_write  = (mmio_ctrl_i == UART_WRITE);

    assign tx_valid_o  = is_write && (mmio_addr == TX_DATA_ADDR);
    assign tx_byte_o   = store_data_i[7:0];
    assign rx_read_o   = is_read && (mmio_addr == RX_DATA_ADDR);
    assign count_clr_o = is_write && (mmio_addr == COUNT_CLR_ADDR);

    // Keeps the last received byte so a read after valid drops still returns it
    always_ff @(posedge clk) begin
        if (rx_valid_i) begin
            rx_byte_q <= rx_byte_i;
        end
    end

    always_comb begin
        case (mmio_addr)
            STATUS_ADDR:  mmio_rdata = {30'b0, rx_valid_i, tx_ready_i};
            RX_DATA_ADDR: mmio_rdata = {24'b0, rx_byte_q};
            CYCLE_ADDR:   mmio_rdata = cycle_count_i;
            INSTR_ADDR:   mmio_rdata = inst_count_i;
            default:      mmio_rdata = '0;
        endcase
    end

    always_comb begin
        wb_d          = ex_i;
        wb_d.byte_off = ex_i.alu_result[1:0];
    end

    always_ff @(posedge clk) begin
        wb_q         <= wb_d;
        mmio_rdata_o <= mmio_rdata;  // Value as seen in the execute cycle
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_en_q <= 1'b0;
        end else begin
            wb_en_q <= ex_i.wb_en;
        end
    end

    always_comb begin
        wb_o       = wb_q;
        wb_o.wb_en = wb_en_q;
    end

    // Software polls the status word first, so the transmitter must already be idle
    tx_write_when_ready: assert property (@(posedge clk) disable iff (reset_i)
        tx_valid_o |-> tx_ready_i)
        else $error("transmit write issued while the UART transmitter is busy");

endmodule

/* hdl/mmio_pkg.sv */
package mmio_pkg;
    import cpu_pkg::*;

    localparam word_t STATUS_ADDR    = 32'h8000_0000;  // Bit 1 rx valid, bit 0 tx ready
    localparam word_t RX_DATA_ADDR   = 32'h8000_0004;
    localparam word_t TX_DATA_ADDR   = 32'h8000_0008;
    localparam word_t CYCLE_ADDR     = 32'h8000_0010;
    localparam word_t INSTR_ADDR     = 32'h8000_0014;
    localparam word_t COUNT_CLR_ADDR = 32'h8000_0018;  // Any store here zeroes both counters

    // Kind of memory-mapped access made by the instruction in execute
    typedef enum logic [1:0] {
        UART_NONE,
        UART_READ,
        UART_WRITE
    } uart_ctrl_e;

    typedef logic [7:0] uart_byte_t;

endpackage

/* hdl/cpu_pkg.sv */
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [1:0]  byte_off_t;

    // Source of the value written back to the register file
    typedef enum logic [1:0] {
        WB_ALU,
        WB_PC4,
        WB_LOAD,
        WB_MMIO
    } wb_sel_e;

    // LD_NONE and LD_LW both pass the memory word through untouched
    typedef enum logic [2:0] {
        LD_NONE,
        LD_LB,
        LD_LH,
        LD_LW,
        LD_LBU,
        LD_LHU
    } load_e;

    typedef struct packed {
        word_t     alu_result;
        word_t     pc_plus4;
        reg_addr_t wb_addr;
        wb_sel_e   wb_sel;
        load_e     load;
        logic      wb_en;
        byte_off_t byte_off;   // Low bits of the load address
    } ex_wb_s;

endpackage
